//--- rtl/soc_macros.svh
// --------------------
// soc bus widths, counts and address map
// --------------------
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define SOC_ADDR_W 16
`define SOC_DATA_W 16

// masters and slaves on the shared bus
`define SOC_CORES  2
`define SOC_SLAVES 4

// peripheral sizes
`define SOC_GPIO0_PINS 8
`define SOC_GPIO1_PINS 16
`define SOC_BRAM_CELLS 64
`define SOC_REGS_CELLS 8

// slave page lives in the top address nibble
`define SOC_PAGE_MSB 15
`define SOC_PAGE_LSB 12

// slave index per page value, others unmapped
`define SOC_PSELX_GPIO0 0
`define SOC_PSELX_GPIO1 1
`define SOC_PSELX_REGS0 2
`define SOC_PSELX_BRAM0 3

`endif

//--- rtl/soc_pkg.sv
// --------------------
// soc bus types shared by the interconnect and slaves
// --------------------
`include "soc_macros.svh"

package soc_pkg;

    // request from a master, or the shared bus toward the slaves
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] addr;
        logic                   write;
        logic                   sel;
        logic                   enable;
        logic [`SOC_DATA_W-1:0] wdata;
    } apb_req_t;

    // slave or master response
    typedef struct packed {
        logic [`SOC_DATA_W-1:0] rdata;
        logic                   ready;
    } apb_rsp_t;

    // interconnect phases
    typedef enum logic [1:0] {
        bus_idle,
        bus_setup,
        bus_access
    } bus_state_e;

    // access kind
    typedef enum logic {
        op_read,
        op_write
    } apb_op_e;

endpackage

//--- rtl/apb_intercon.sv
// --------------------
// apb interconnect with round-robin arbitration, decode and response return
// --------------------
`timescale 1ns/1ps
`include "soc_macros.svh"

module apb_intercon (
    input  logic                      clk,
    input  logic                      rst,
    input  soc_pkg::apb_req_t         m_req [`SOC_CORES],
    output soc_pkg::apb_rsp_t         m_rsp [`SOC_CORES],
    output soc_pkg::apb_req_t         bus_req,
    output logic [`SOC_SLAVES-1:0]    bus_sel,
    input  soc_pkg::apb_rsp_t         slv_rsp [`SOC_SLAVES]
);

    localparam int GNT_W = (`SOC_CORES > 1) ? $clog2(`SOC_CORES) : 1;

    soc_pkg::bus_state_e state_q;
    logic [GNT_W-1:0]    last_q;
    logic [GNT_W-1:0]    grant_q;
    logic                sel_q;
    logic                enable_q;

    logic [`SOC_ADDR_W-1:0] addr_q;
    logic [`SOC_DATA_W-1:0] wdata_q;
    soc_pkg::apb_op_e       op_q;

    logic                   pick_valid;
    logic [GNT_W-1:0]       pick_idx;
    logic [`SOC_PAGE_MSB-`SOC_PAGE_LSB:0] page;
    logic                   mapped;
    logic [`SOC_DATA_W-1:0] sel_rdata;
    logic                   sel_ready;

    // round robin search starting one past the last winner
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = last_q;
        for (int k = 1; k <= `SOC_CORES; k++) begin
            cand = (int'(last_q) + k) % `SOC_CORES;
            if (!pick_valid && m_req[cand].sel) begin
                pick_valid = 1'b1;
                pick_idx   = GNT_W'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= soc_pkg::bus_idle;
            last_q   <= GNT_W'(`SOC_CORES - 1);
            grant_q  <= '0;
            sel_q    <= 1'b0;
            enable_q <= 1'b0;
        end else begin
            case (state_q)
                soc_pkg::bus_idle: begin
                    if (pick_valid) begin
                        state_q <= soc_pkg::bus_setup;
                        grant_q <= pick_idx;
                        sel_q   <= 1'b1;
                    end
                end
                soc_pkg::bus_setup: begin
                    state_q  <= soc_pkg::bus_access;
                    enable_q <= 1'b1;
                end
                soc_pkg::bus_access: begin
                    // slave holding ready low keeps us here
                    if (sel_ready) begin
                        state_q  <= soc_pkg::bus_idle;
                        last_q   <= grant_q;
                        sel_q    <= 1'b0;
                        enable_q <= 1'b0;
                    end
                end
                default: state_q <= soc_pkg::bus_idle;
            endcase
        end
    end

    // winner's fields are captured as the grant is made
    always_ff @(posedge clk) begin
        if (state_q == soc_pkg::bus_idle && pick_valid) begin
            addr_q  <= m_req[pick_idx].addr;
            wdata_q <= m_req[pick_idx].wdata;
            op_q    <= m_req[pick_idx].write ? soc_pkg::op_write : soc_pkg::op_read;
        end
    end

    assign bus_req = '{addr:   addr_q,
                       write:  (op_q == soc_pkg::op_write),
                       sel:    sel_q,
                       enable: enable_q,
                       wdata:  wdata_q};

    assign page = addr_q[`SOC_PAGE_MSB:`SOC_PAGE_LSB];

    always_comb begin
        bus_sel = '0;
        mapped  = 1'b1;
        case (page)
            `SOC_PSELX_GPIO0: bus_sel[`SOC_PSELX_GPIO0] = sel_q;
            `SOC_PSELX_GPIO1: bus_sel[`SOC_PSELX_GPIO1] = sel_q;
            `SOC_PSELX_REGS0: bus_sel[`SOC_PSELX_REGS0] = sel_q;
            `SOC_PSELX_BRAM0: bus_sel[`SOC_PSELX_BRAM0] = sel_q;
            default:          mapped = 1'b0;
        endcase
    end

    // unmapped pages answer at once with zero data
    always_comb begin
        sel_rdata = '0;
        sel_ready = !mapped;
        for (int s = 0; s < `SOC_SLAVES; s++) begin
            if (bus_sel[s]) begin
                sel_rdata = sel_rdata | slv_rsp[s].rdata;
                sel_ready = slv_rsp[s].ready;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SOC_CORES; i++) begin
            m_rsp[i].ready = (state_q == soc_pkg::bus_access) && (grant_q == GNT_W'(i))
                             && sel_ready;
            m_rsp[i].rdata = (grant_q == GNT_W'(i)) ? sel_rdata : '0;
        end
    end

    // a slave is selected only while a transfer holds the bus
    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bus_sel) && (state_q != soc_pkg::bus_idle || bus_sel == '0));

    a_enable_sel: assert property (@(posedge clk) disable iff (rst)
        bus_req.enable |-> bus_req.sel);

    // master must keep its request up for the whole grant
    a_grant_hold: assert property (@(posedge clk) disable iff (rst)
        (state_q != soc_pkg::bus_idle) |-> m_req[grant_q].sel);

endmodule

//--- rtl/gpio_apb.sv
// --------------------
// gpio output register on the apb bus
// --------------------
`timescale 1ns/1ps
`include "soc_macros.svh"

module gpio_apb #(
    parameter int PORTS = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  soc_pkg::apb_req_t bus_req,
    input  logic              sel,
    output soc_pkg::apb_rsp_t rsp,
    output logic [PORTS-1:0]  gpio
);

    logic access;

    assign access = sel && bus_req.enable;

    // any address hits the one register
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio <= '0;
        end else if (access && bus_req.write) begin
            gpio <= bus_req.wdata[PORTS-1:0];
        end
    end

    // no wait states
    assign rsp.ready = access;
    assign rsp.rdata = `SOC_DATA_W'(gpio);

endmodule

//--- rtl/info_regs_apb.sv
// --------------------
// soc info registers, R0/R1 read-only counts, R2-R7 scratch
// --------------------
`timescale 1ns/1ps
`include "soc_macros.svh"

module info_regs_apb (
    input  logic              clk,
    input  logic              rst,
    input  soc_pkg::apb_req_t bus_req,
    input  logic              sel,
    output soc_pkg::apb_rsp_t rsp
);

    localparam int IDX_W = $clog2(`SOC_REGS_CELLS);

    logic [`SOC_DATA_W-1:0] scratch [2:`SOC_REGS_CELLS-1];
    logic [IDX_W-1:0]       idx;
    logic                   access;

    assign access = sel && bus_req.enable;
    assign idx    = bus_req.addr[IDX_W-1:0];

    // writes to R0 and R1 are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 2; k < `SOC_REGS_CELLS; k++) begin
                scratch[k] <= '0;
            end
        end else if (access && bus_req.write && idx >= IDX_W'(2)) begin
            scratch[idx] <= bus_req.wdata;
        end
    end

    always_comb begin
        case (idx)
            IDX_W'(0): rsp.rdata = `SOC_DATA_W'(`SOC_CORES);
            IDX_W'(1): rsp.rdata = `SOC_DATA_W'(`SOC_SLAVES);
            default:   rsp.rdata = scratch[idx];
        endcase
    end

    assign rsp.ready = access;

    // ready only inside an enabled access that followed a select
    a_ready_access: assert property (@(posedge clk) disable iff (rst)
        rsp.ready |-> bus_req.sel && bus_req.enable && $past(bus_req.sel));

endmodule

//--- rtl/bram_apb.sv
// --------------------
// block ram slave, one wait state per access
// --------------------
`timescale 1ns/1ps
`include "soc_macros.svh"

module bram_apb #(
    parameter int MEM_DEPTH = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  soc_pkg::apb_req_t bus_req,
    input  logic              sel,
    output soc_pkg::apb_rsp_t rsp
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    logic [`SOC_DATA_W-1:0] mem [MEM_DEPTH];
    logic [`SOC_DATA_W-1:0] rdata_q;
    logic                   wait_q;
    logic                   access;
    logic [IDX_W-1:0]       idx;

    assign access = sel && bus_req.enable;
    // address wraps modulo the depth
    assign idx    = bus_req.addr[IDX_W-1:0];

    // set during the first access cycle, cleared as the access completes
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_q <= 1'b0;
        end else if (access) begin
            wait_q <= !wait_q;
        end else begin
            wait_q <= 1'b0;
        end
    end

    // registered read in the wait cycle, write on the completing edge
    always_ff @(posedge clk) begin
        if (access && !wait_q) begin
            rdata_q <= mem[idx];
        end
        if (access && wait_q && bus_req.write) begin
            mem[idx] <= bus_req.wdata;
        end
    end

    assign rsp.ready = access && wait_q;
    assign rsp.rdata = rdata_q;

    // completion needs the bus select and an address held through the wait cycle
    a_ready_wait: assert property (@(posedge clk) disable iff (rst)
        rsp.ready |-> bus_req.sel && bus_req.enable && $stable(bus_req.addr));

endmodule

//--- rtl/soc_top.sv
// --------------------
// soc top level with the apb interconnect, gpio, info regs and bram
// --------------------
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top (
    input  logic                         clk,
    input  logic                         rst,
    input  soc_pkg::apb_req_t            m_req [`SOC_CORES],
    output soc_pkg::apb_rsp_t            m_rsp [`SOC_CORES],
    output logic [`SOC_GPIO0_PINS-1:0]   gpio0,
    output logic [`SOC_GPIO1_PINS-1:0]   gpio1
);

    // shared bus
    soc_pkg::apb_req_t        bus_req;
    logic [`SOC_SLAVES-1:0]   bus_sel;
    soc_pkg::apb_rsp_t        slv_rsp [`SOC_SLAVES];

    apb_intercon i_intercon (
        .clk     (clk),
        .rst     (rst),
        .m_req   (m_req),
        .m_rsp   (m_rsp),
        .bus_req (bus_req),
        .bus_sel (bus_sel),
        .slv_rsp (slv_rsp)
    );

    gpio_apb #(
        .PORTS (`SOC_GPIO0_PINS)
    ) i_gpio0 (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .sel     (bus_sel[`SOC_PSELX_GPIO0]),
        .rsp     (slv_rsp[`SOC_PSELX_GPIO0]),
        .gpio    (gpio0)
    );

    // wider port, e.g. for display segments
    gpio_apb #(
        .PORTS (`SOC_GPIO1_PINS)
    ) i_gpio1 (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .sel     (bus_sel[`SOC_PSELX_GPIO1]),
        .rsp     (slv_rsp[`SOC_PSELX_GPIO1]),
        .gpio    (gpio1)
    );

    info_regs_apb i_regs0 (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .sel     (bus_sel[`SOC_PSELX_REGS0]),
        .rsp     (slv_rsp[`SOC_PSELX_REGS0])
    );

    bram_apb #(
        .MEM_DEPTH (`SOC_BRAM_CELLS)
    ) i_bram0 (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .sel     (bus_sel[`SOC_PSELX_BRAM0]),
        .rsp     (slv_rsp[`SOC_PSELX_BRAM0])
    );

endmodule

//--- test/tb_soc.sv
// --------------------
// soc testbench with two bus masters checked against a shadow model
// --------------------
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc;

    localparam int WAIT_LIMIT = 40;

    typedef struct packed {
        soc_pkg::apb_op_e       op;
        logic [7:0]             master;
        logic [`SOC_ADDR_W-1:0] addr;
        logic [`SOC_DATA_W-1:0] exp;
        logic [`SOC_DATA_W-1:0] act;
    } xfer_rec_t;

    logic                       clk;
    logic                       rst;
    soc_pkg::apb_req_t          m_req [`SOC_CORES];
    soc_pkg::apb_rsp_t          m_rsp [`SOC_CORES];
    logic [`SOC_GPIO0_PINS-1:0] gpio0;
    logic [`SOC_GPIO1_PINS-1:0] gpio1;

    // shadow model of everything a read can observe
    logic [`SOC_DATA_W-1:0]     scratch_m [`SOC_REGS_CELLS];
    logic [`SOC_DATA_W-1:0]     ram_m [`SOC_BRAM_CELLS];
    logic [`SOC_GPIO0_PINS-1:0] gpio0_m;
    logic [`SOC_GPIO1_PINS-1:0] gpio1_m;

    xfer_rec_t done_q [$];
    int        errors;
    int        timeouts;
    int        reads_checked;

    soc_top i_soc_top (
        .clk   (clk),
        .rst   (rst),
        .m_req (m_req),
        .m_rsp (m_rsp),
        .gpio0 (gpio0),
        .gpio1 (gpio1)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] expected_read(input logic [15:0] addr);
        case (addr[15:12])
            4'(`SOC_PSELX_GPIO0): return 16'(gpio0_m);
            4'(`SOC_PSELX_GPIO1): return 16'(gpio1_m);
            4'(`SOC_PSELX_REGS0): begin
                // R0 master count, R1 slave count
                if (addr[2:0] == 3'd0) return 16'd2;
                if (addr[2:0] == 3'd1) return 16'd4;
                return scratch_m[addr[2:0]];
            end
            4'(`SOC_PSELX_BRAM0): return ram_m[addr[5:0]];
            default: return '0;
        endcase
    endfunction

    function automatic void model_write(input logic [15:0] addr, input logic [15:0] data);
        case (addr[15:12])
            4'(`SOC_PSELX_GPIO0): gpio0_m = data[`SOC_GPIO0_PINS-1:0];
            4'(`SOC_PSELX_GPIO1): gpio1_m = data[`SOC_GPIO1_PINS-1:0];
            4'(`SOC_PSELX_REGS0): if (addr[2:0] >= 3'd2) scratch_m[addr[2:0]] = data;
            4'(`SOC_PSELX_BRAM0): ram_m[addr[5:0]] = data;
            default: ;
        endcase
    endfunction

    task automatic check_equal(input string what, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp) else begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, act);
            errors++;
        end
    endtask

    // one transfer on master m that returns 1 ns after the completing edge
    task automatic master_xfer(input int m, input soc_pkg::apb_op_e op,
                               input logic [15:0] addr, input logic [15:0] wdata);
        xfer_rec_t rec;
        int        cyc;
        bit        seen;
        @(posedge clk);
        #1;
        m_req[m] = '{addr: addr, write: (op == soc_pkg::op_write), sel: 1'b1,
                     enable: 1'b0, wdata: wdata};
        @(posedge clk);
        #1;
        m_req[m].enable = 1'b1;
        seen = 1'b0;
        cyc  = 0;
        // ready is settled by the falling edge
        while (!seen && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            seen = m_rsp[m].ready;
            cyc++;
        end
        if (seen) begin
            // only the granted master may see ready
            for (int o = 0; o < `SOC_CORES; o++) begin
                if (o != m) begin
                    check_equal("ready of a waiting master", 16'd0, 16'(m_rsp[o].ready));
                end
            end
            rec.op     = op;
            rec.master = 8'(m);
            rec.addr   = addr;
            rec.act    = m_rsp[m].rdata;
            rec.exp    = expected_read(addr);
            if (op == soc_pkg::op_write) model_write(addr, wdata);
            done_q.push_back(rec);
        end else begin
            $display("ERROR: master %0d saw no ready within %0d cycles for address %h",
                     m, WAIT_LIMIT, addr);
            timeouts++;
        end
        @(posedge clk);
        #1;
        m_req[m].sel    = 1'b0;
        m_req[m].enable = 1'b0;
    endtask

    task automatic ram_stream(input int m, input int count, input logic [11:0] mask,
                              input logic [11:0] half);
        logic [15:0]      addr;
        soc_pkg::apb_op_e op;
        for (int i = 0; i < count; i++) begin
            addr = {4'(`SOC_PSELX_BRAM0), (12'($urandom) & mask) | half};
            op   = ($urandom_range(0, 1) == 1) ? soc_pkg::op_write : soc_pkg::op_read;
            master_xfer(m, op, addr, 16'($urandom));
        end
    endtask

    // compare process
    always @(posedge clk) begin
        xfer_rec_t rec;
        while (done_q.size() > 0) begin
            rec = done_q.pop_front();
            if (rec.op == soc_pkg::op_read) begin
                reads_checked++;
                assert (rec.act === rec.exp) else begin
                    $display("MISMATCH at %0t: master %0d read %h expected %h got %h",
                             $time, rec.master, rec.addr, rec.exp, rec.act);
                    errors++;
                end
            end
        end
    end

    initial begin
        logic [15:0] addr;
        clk           = 1'b0;
        rst           = 1'b1;
        m_req[0]      = '0;
        m_req[1]      = '0;
        errors        = 0;
        timeouts      = 0;
        reads_checked = 0;
        gpio0_m       = '0;
        gpio1_m       = '0;
        foreach (scratch_m[k]) scratch_m[k] = '0;
        void'($urandom(73));
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        check_equal("ready m0 after reset", 16'd0, 16'(m_rsp[0].ready));
        check_equal("ready m1 after reset", 16'd0, 16'(m_rsp[1].ready));
        check_equal("gpio0 after reset", 16'd0, 16'(gpio0));
        check_equal("gpio1 after reset", 16'd0, 16'(gpio1));

        // read-only info cells
        master_xfer(0, soc_pkg::op_read, 16'h2000, '0);
        master_xfer(1, soc_pkg::op_read, 16'h2001, '0);
        master_xfer(0, soc_pkg::op_write, 16'h2000, 16'hffff);
        master_xfer(1, soc_pkg::op_write, 16'h2001, 16'h1234);
        master_xfer(0, soc_pkg::op_read, 16'h2000, '0);
        master_xfer(1, soc_pkg::op_read, 16'h2001, '0);

        for (int r = 2; r < 8; r++) master_xfer(0, soc_pkg::op_read, 16'h2000 | 16'(r), '0);
        for (int r = 2; r < 8; r++) begin
            master_xfer(r % 2, soc_pkg::op_write, 16'h2000 | 16'(r), 16'($urandom));
        end
        for (int r = 2; r < 8; r++) master_xfer(1, soc_pkg::op_read, 16'h2000 | 16'(r), '0);

        // gpio pins follow on the completing edge
        master_xfer(0, soc_pkg::op_write, 16'h0004, 16'habcd);
        check_equal("gpio0 pins", 16'h00cd, 16'(gpio0));
        master_xfer(1, soc_pkg::op_write, 16'h1010, 16'h5a5a);
        check_equal("gpio1 pins", 16'h5a5a, 16'(gpio1));
        master_xfer(0, soc_pkg::op_read, 16'h0000, '0);
        master_xfer(1, soc_pkg::op_read, 16'h1ffe, '0);

        for (int i = 0; i < `SOC_BRAM_CELLS; i++) begin
            addr = 16'h3000 | 16'(i);
            master_xfer(0, soc_pkg::op_write, addr, {addr[7:0], addr[15:8]} ^ 16'h5a3c);
        end
        ram_stream(0, 48, 12'hfff, 12'h000);

        // both masters at once on ram halves split by address bit 5
        fork
            ram_stream(0, 32, 12'hfdf, 12'h000);
            ram_stream(1, 32, 12'hfdf, 12'h020);
        join

        master_xfer(0, soc_pkg::op_read, 16'h4000, '0);
        master_xfer(1, soc_pkg::op_read, 16'h8123, '0);
        master_xfer(0, soc_pkg::op_write, 16'h5000, 16'hffff);
        master_xfer(1, soc_pkg::op_write, 16'h7003, 16'h1234);
        master_xfer(0, soc_pkg::op_write, 16'hf002, 16'h0bad);
        check_equal("gpio0 after unmapped writes", 16'(gpio0_m), 16'(gpio0));
        check_equal("gpio1 after unmapped writes", 16'(gpio1_m), 16'(gpio1));
        master_xfer(0, soc_pkg::op_read, 16'h2002, '0);
        master_xfer(1, soc_pkg::op_read, 16'h2003, '0);
        master_xfer(0, soc_pkg::op_read, 16'h3003, '0);
        master_xfer(1, soc_pkg::op_read, 16'h3002, '0);

        for (int w = 0; w < 10 && done_q.size() > 0; w++) @(posedge clk);
        if (done_q.size() > 0) begin
            $display("ERROR: %0d completed transfers were never compared", done_q.size());
            errors++;
        end

        $display("reads checked %0d, errors %0d, timeouts %0d",
                 reads_checked, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+rtl
rtl/soc_pkg.sv
rtl/apb_intercon.sv
rtl/gpio_apb.sv
rtl/info_regs_apb.sv
rtl/bram_apb.sv
rtl/soc_top.sv
test/tb_soc.sv

//--- Bender.yml
package:
  name: apb_soc

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_pkg.sv
      - rtl/apb_intercon.sv
      - rtl/gpio_apb.sv
      - rtl/info_regs_apb.sv
      - rtl/bram_apb.sv
      - rtl/soc_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_soc.sv
